// ==== sources.f ====
+incdir+.
daq_pkg.sv
sample_fifo.sv
packet_sender.sv
link_sync.sv
daq_top.sv
tb_daq_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the DAQ testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -f sources.f --top-module tb_daq_top \
	-o tb_daq_top > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/tb_daq_top > sim.log 2>&1
grep -q "TEST FAILED" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"

// ==== tb_daq_top.sv ====
`timescale 1ns/1ps
`include "daq_params.svh"

module tb_daq_top
	import daq_pkg::*;
();

	localparam int CYCLE_LIMIT = 20000;	// About ten times the whole sequence

	logic          GMII_GTX_CLK_int = 1'b0;
	logic          rst_mux_div;
	logic          adc_we_i;
	data_word_t    adc_data_i;
	logic          cfg_we_i;
	data_word_t    cfg_data_i;
	data_word_t    tx_data_o;
	stream_flags_t tx_flags_o;
	logic          tx_src_rdy_o;
	logic          tx_dst_rdy_i;
	mux_word_t     mux_in_i = `SYNC_IDLE;
	logic [6:0]    sw_i;
	mux_word_t     mux_out_o;
	logic          bitslip_o;
	logic          synced_o;

	// One scoreboard queue per source
	data_word_t    cfg_q[$];
	data_word_t    adc_q[$];
	logic          exp_adc = 1'b1;	// Source of the packet on the stream
	int            exp_idx = 0;
	data_word_t    exp_word = '0;
	stream_flags_t exp_flags = '0;
	logic          exp_valid = 1'b0;
	logic          xfer;
	logic          xfer_seen = 1'b0;
	int            pkt_done = 0;

	logic          echo_on = 1'b0;
	mux_word_t     far_word = `SYNC_IDLE;	// Far side output while echo is off
	logic          hold_window = 1'b0;
	int            cycle = 0;
	int            err_cnt = 0;
	int            err_base = 0;
	int            test_cnt = 0;
	int            test_fail = 0;

	daq_top daq_top_i (.*);

	always #2 GMII_GTX_CLK_int = ~GMII_GTX_CLK_int;

	always @(posedge GMII_GTX_CLK_int) begin
		cycle <= cycle + 1;
		if (cycle >= CYCLE_LIMIT) begin
			$display("Run stopped after %0d cycles, a test never finished", cycle);
			$display("TEST FAILED");
			$finish;
		end
	end

	// Far side loops our mux word back one cycle later
	always @(negedge GMII_GTX_CLK_int)
		mux_in_i <= echo_on ? mux_out_o : far_word;

	////////////////////////////////////////
	// Scoreboard

	assign xfer = tx_src_rdy_o & tx_dst_rdy_i;

	always @(posedge GMII_GTX_CLK_int)
		xfer_seen <= xfer && !rst_mux_div;

	// Retire the word taken at the last rising edge, then set up the next one
	always @(negedge GMII_GTX_CLK_int) begin
		if (xfer_seen) begin
			if (exp_adc && adc_q.size() > 0)
				void'(adc_q.pop_front());
			else if (!exp_adc && cfg_q.size() > 0)
				void'(cfg_q.pop_front());
			if (exp_idx == `PKT_WORDS - 1) begin
				exp_idx = 0;
				pkt_done++;
			end else
				exp_idx++;
		end
		// Config wins whenever a whole config packet waits
		if (exp_idx == 0)
			exp_adc = (cfg_q.size() < `PKT_WORDS);
		exp_valid = exp_adc ? (adc_q.size() > 0) : (cfg_q.size() > 0);
		if (!exp_valid)
			exp_word = '0;
		else if (exp_adc)
			exp_word = adc_q[0];
		else
			exp_word = cfg_q[0];
		exp_flags = '0;
		exp_flags[`FLAG_SOF_BIT] = (exp_idx == 0);
		exp_flags[`FLAG_EOF_BIT] = (exp_idx == `PKT_WORDS - 1);
	end

	task automatic show_error(input string sig, input logic [31:0] exp_val,
		input logic [31:0] act_val);
		$display("** Error at %0t: %s expected %0h actual %0h", $time, sig, exp_val, act_val);
		err_cnt++;
	endtask

	task automatic note_failure(input string msg);
		$display("%s at %0t", msg, $time);
		err_cnt++;
	endtask

	////////////////////////////////////////
	// Checks

	a_data: assert property (@(posedge GMII_GTX_CLK_int) disable iff (rst_mux_div)
		xfer |-> exp_valid && tx_data_o == exp_word)
		else begin
			if (!$sampled(exp_valid))
				note_failure("Stream word with nothing left to send");
			else
				show_error("tx_data_o", $sampled(exp_word), $sampled(tx_data_o));
		end

	a_flags: assert property (@(posedge GMII_GTX_CLK_int) disable iff (rst_mux_div)
		xfer |-> tx_flags_o == exp_flags)
		else show_error("tx_flags_o", 32'($sampled(exp_flags)), 32'($sampled(tx_flags_o)));

	a_stall: assert property (@(posedge GMII_GTX_CLK_int) disable iff (rst_mux_div)
		tx_src_rdy_o && !tx_dst_rdy_i |=>
			tx_src_rdy_o && $stable(tx_data_o) && $stable(tx_flags_o))
		else note_failure("Stream word changed or dropped while stalled");

	a_hold: assert property (@(posedge GMII_GTX_CLK_int) disable iff (rst_mux_div)
		hold_window |-> !tx_src_rdy_o)
		else note_failure("Packet started with less than a packet stored");

	// Heartbeat flips every cycle once locked
	a_heartbeat: assert property (@(posedge GMII_GTX_CLK_int) disable iff (rst_mux_div)
		synced_o && $past(synced_o) |-> mux_out_o[7] != $past(mux_out_o[7]))
		else show_error("mux_out_o[7]", 32'(!$sampled(mux_out_o[7])),
			32'($sampled(mux_out_o[7])));

	a_switches: assert property (@(posedge GMII_GTX_CLK_int) disable iff (rst_mux_div)
		synced_o |-> mux_out_o[6:0] == sw_i)
		else show_error("mux_out_o[6:0]", 32'($sampled(sw_i)), 32'($sampled(mux_out_o[6:0])));

	a_slip_gap: assert property (@(posedge GMII_GTX_CLK_int) disable iff (rst_mux_div)
		bitslip_o |-> !$past(bitslip_o) && !$past(bitslip_o, 2))
		else note_failure("Two bitslip pulses within three cycles");

	////////////////////////////////////////
	// Stimulus

	task automatic report_test(input string name);
		int errs;
		errs = err_cnt - err_base;
		test_cnt++;
		if (errs == 0) begin
			$display("%-22s pass", name);
		end else begin
			test_fail++;
			$display("%-22s fail, %0d errors", name, errs);
		end
		err_base = err_cnt;
	endtask

	// One word per cycle into the chosen sources
	task automatic write_words(input int n, input bit to_cfg, input bit to_adc,
		input bit rand_bp);
		for (int i = 0; i < n; i++) begin
			@(negedge GMII_GTX_CLK_int);
			adc_we_i   = to_adc;
			cfg_we_i   = to_cfg;
			adc_data_i = $urandom;
			cfg_data_i = $urandom;
			if (to_adc)
				adc_q.push_back(adc_data_i);
			if (to_cfg)
				cfg_q.push_back(cfg_data_i);
			if (rand_bp)
				tx_dst_rdy_i = ($urandom % 2) == 1;
		end
		@(negedge GMII_GTX_CLK_int);
		adc_we_i = 1'b0;
		cfg_we_i = 1'b0;
	endtask

	task automatic wait_packets(input int target, input bit rand_bp);
		while (pkt_done < target) begin
			@(negedge GMII_GTX_CLK_int);
			if (rand_bp)
				tx_dst_rdy_i = ($urandom % 2) == 1;
		end
	endtask

	initial begin
		int start;
		int slips;
		int wait_cyc;
		void'($urandom(32'hbea8_1aa8));
		rst_mux_div  = 1'b1;
		adc_we_i     = 1'b0;
		adc_data_i   = '0;
		cfg_we_i     = 1'b0;
		cfg_data_i   = '0;
		tx_dst_rdy_i = 1'b1;
		sw_i         = '0;
		repeat (3) @(posedge GMII_GTX_CLK_int);
		@(negedge GMII_GTX_CLK_int);
		rst_mux_div = 1'b0;

		// One ADC packet into a sink that is always ready
		start = pkt_done;
		write_words(`PKT_WORDS, 1'b0, 1'b1, 1'b0);
		wait_packets(start + 1, 1'b0);
		hold_window = 1'b1;	// Empty FIFO, nothing more may start
		repeat (20) @(negedge GMII_GTX_CLK_int);
		hold_window = 1'b0;
		report_test("adc packet");

		// Both sources fill together behind a stalled sink
		start = pkt_done;
		tx_dst_rdy_i = 1'b0;
		write_words(`PKT_WORDS, 1'b1, 1'b1, 1'b0);
		repeat (10) @(negedge GMII_GTX_CLK_int);
		tx_dst_rdy_i = 1'b1;
		wait_packets(start + 2, 1'b0);
		report_test("config priority");

		start = pkt_done;
		write_words(`PKT_WORDS, 1'b0, 1'b1, 1'b1);
		wait_packets(start + 1, 1'b1);
		tx_dst_rdy_i = 1'b1;
		report_test("back-pressure");

		// 100 words must sit in the FIFO
		start = pkt_done;
		write_words(100, 1'b0, 1'b1, 1'b0);
		hold_window = 1'b1;
		repeat (300) @(negedge GMII_GTX_CLK_int);
		hold_window = 1'b0;
		write_words(`PKT_WORDS - 100, 1'b0, 1'b1, 1'b0);
		wait_packets(start + 1, 1'b0);
		hold_window = 1'b1;
		repeat (20) @(negedge GMII_GTX_CLK_int);
		hold_window = 1'b0;
		report_test("partial packet held");

		echo_on = 1'b1;
		wait_cyc = 0;
		while (!synced_o && wait_cyc < 50) begin
			@(negedge GMII_GTX_CLK_int);
			wait_cyc++;
		end
		if (!synced_o)
			note_failure("Link did not reach sync with the echo on");
		repeat (40) begin	// Switches move under the heartbeat
			@(negedge GMII_GTX_CLK_int);
			sw_i = 7'($urandom);
		end
		if (!synced_o)
			note_failure("Link dropped sync with the echo on");
		report_test("link training");

		// Far side goes quiet on a word that is no pattern
		far_word = mux_word_t'($urandom);
		while (far_word == `SYNC_IDLE || far_word == `SYNC_LOCK)
			far_word = mux_word_t'($urandom);
		echo_on = 1'b0;
		wait_cyc = 0;
		while (synced_o && wait_cyc < 20) begin
			@(negedge GMII_GTX_CLK_int);
			wait_cyc++;
		end
		if (synced_o)
			note_failure("Sync held after the far side went quiet");
		slips = 0;
		repeat (40) begin
			@(negedge GMII_GTX_CLK_int);
			if (bitslip_o)
				slips++;
		end
		if (slips < 2)
			note_failure("No bitslip requests after the link was lost");
		report_test("link loss");

		$display("%0d tests run, %0d failed, %0d errors", test_cnt, test_fail, err_cnt);
		if (err_cnt == 0 && test_fail == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== daq_top.sv ====
`timescale 1ns/1ps
`include "daq_params.svh"

module daq_top
	import daq_pkg::*;
(
	input  logic          GMII_GTX_CLK_int,
	input  logic          rst_mux_div,

	// Sample sources
	input  logic          adc_we_i,
	input  data_word_t    adc_data_i,
	input  logic          cfg_we_i,
	input  data_word_t    cfg_data_i,

	// Packet stream out
	output data_word_t    tx_data_o,
	output stream_flags_t tx_flags_o,
	output logic          tx_src_rdy_o,
	input  logic          tx_dst_rdy_i,

	// Board-to-board serial mux
	input  mux_word_t     mux_in_i,
	input  logic [6:0]    sw_i,
	output mux_word_t     mux_out_o,
	output logic          bitslip_o,
	output logic          synced_o
);

	data_word_t cfg_head;
	data_word_t adc_head;
	logic       cfg_pkt_ready;
	logic       adc_pkt_ready;
	logic       cfg_rd;
	logic       adc_rd;

	////////////////////////////////////////
	// Sample FIFOs

	sample_fifo u_cfg_fifo (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.rst_mux_div      (rst_mux_div),
		.wr_en_i          (cfg_we_i),
		.wr_data_i        (cfg_data_i),
		.rd_en_i          (cfg_rd),
		.rd_data_o        (cfg_head),
		.pkt_ready_o      (cfg_pkt_ready),
		.full_o           ()	// Checked inside the FIFO
	);

	sample_fifo u_adc_fifo (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.rst_mux_div      (rst_mux_div),
		.wr_en_i          (adc_we_i),
		.wr_data_i        (adc_data_i),
		.rd_en_i          (adc_rd),
		.rd_data_o        (adc_head),
		.pkt_ready_o      (adc_pkt_ready),
		.full_o           ()
	);

	////////////////////////////////////////
	// Arbiter, config has priority

	packet_sender u_packet_sender (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.rst_mux_div      (rst_mux_div),
		.pri_pkt_ready_i  (cfg_pkt_ready),
		.pri_data_i       (cfg_head),
		.pri_rd_o         (cfg_rd),
		.sec_pkt_ready_i  (adc_pkt_ready),
		.sec_data_i       (adc_head),
		.sec_rd_o         (adc_rd),
		.tx_data_o        (tx_data_o),
		.tx_flags_o       (tx_flags_o),
		.tx_src_rdy_o     (tx_src_rdy_o),
		.tx_dst_rdy_i     (tx_dst_rdy_i)
	);

	link_sync u_link_sync (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.rst_mux_div      (rst_mux_div),
		.mux_in_i         (mux_in_i),
		.sw_i             (sw_i),
		.mux_out_o        (mux_out_o),
		.bitslip_o        (bitslip_o),
		.synced_o         (synced_o)
	);

endmodule

// ==== link_sync.sv ====
`timescale 1ns/1ps
`include "daq_params.svh"

module link_sync
	import daq_pkg::*;
(
	input  logic      GMII_GTX_CLK_int,
	input  logic      rst_mux_div,
	input  mux_word_t mux_in_i,
	input  logic [6:0] sw_i,
	output mux_word_t mux_out_o,
	output logic      bitslip_o,
	output logic      synced_o
);

	sync_state_t state;
	mux_word_t   sync_pattern;	// Training word sent while hunting
	logic        hb_out;
	logic        mon_valid;
	logic        mon_expect;
	logic        slip_d;
	logic        in_is_pattern;

	assign in_is_pattern = (mux_in_i == `SYNC_IDLE) || (mux_in_i == `SYNC_LOCK);
	assign synced_o      = (state == SYNC_LOCKED);

	// Heartbeat on the top bit, switches below it
	assign mux_out_o = synced_o ? {hb_out, sw_i} : sync_pattern;

	always_ff @(posedge GMII_GTX_CLK_int) begin
		if (rst_mux_div) begin
			state        <= SYNC_HUNT;
			sync_pattern <= `SYNC_IDLE;
			hb_out       <= 1'b0;
			mon_valid    <= 1'b0;
			mon_expect   <= 1'b0;
			bitslip_o    <= 1'b0;
			slip_d       <= 1'b0;
		end else begin
			hb_out    <= ~hb_out;	// Far side watches this for link loss
			bitslip_o <= 1'b0;
			slip_d    <= bitslip_o;

			case (state)

				////////////////////////////////////////
				// Locked, check far-side heartbeat

				SYNC_LOCKED: begin
					if (mon_valid) begin
						if (mux_in_i[`MUX_W-1] == mon_expect) begin
							mon_expect <= ~mux_in_i[`MUX_W-1];
						end else begin
							// Missed toggle, retrain
							mon_valid <= 1'b0;
							state     <= SYNC_HUNT;
						end
					end else if (mux_in_i != `SYNC_LOCK) begin
						// Far side has left training
						mon_expect <= ~mux_in_i[`MUX_W-1];
						mon_valid  <= 1'b1;
					end
				end

				////////////////////////////////////////
				// Hunting, exchange patterns

				default: begin
					if (!in_is_pattern) begin
						sync_pattern <= `SYNC_IDLE;
						mon_valid    <= 1'b0;
						if (!bitslip_o && !slip_d)
							bitslip_o <= 1'b1;	// Slip one bit, then wait
					end else begin
						if (mux_in_i == `SYNC_LOCK && sync_pattern == `SYNC_LOCK)
							state <= SYNC_LOCKED;
						sync_pattern <= `SYNC_LOCK;
					end
				end
			endcase
		end
	end

	// Deserializer needs settle time after each slip
	a_slip_spacing: assert property (
		@(posedge GMII_GTX_CLK_int) disable iff (rst_mux_div)
		bitslip_o |=> !bitslip_o [*2]
	) else $error("link_sync: bitslip pulses too close");

endmodule

// ==== packet_sender.sv ====
`timescale 1ns/1ps
`include "daq_params.svh"

module packet_sender
	import daq_pkg::*;
(
	input  logic          GMII_GTX_CLK_int,
	input  logic          rst_mux_div,

	// Primary source, config replies
	input  logic          pri_pkt_ready_i,
	input  data_word_t    pri_data_i,
	output logic          pri_rd_o,

	// Secondary source, ADC samples
	input  logic          sec_pkt_ready_i,
	input  data_word_t    sec_data_i,
	output logic          sec_rd_o,

	// Outgoing packet stream
	output data_word_t    tx_data_o,
	output stream_flags_t tx_flags_o,
	output logic          tx_src_rdy_o,
	input  logic          tx_dst_rdy_i
);

	localparam pkt_cnt_t LAST_IDX = pkt_cnt_t'(`PKT_WORDS - 1);

	sender_state_t state;
	sender_state_t state_nxt;
	pkt_cnt_t      word_idx;
	logic          xfer;
	logic          last_word;

	////////////////////////////////////////
	// Stream side

	assign tx_src_rdy_o = (state != SND_IDLE);
	assign xfer         = tx_src_rdy_o & tx_dst_rdy_i;	// Word leaves on this edge
	assign last_word    = (word_idx == LAST_IDX);

	// FIFO head only moves on a pop, so a stall holds the data
	assign tx_data_o = (state == SND_SEC) ? sec_data_i : pri_data_i;

	always_comb begin
		tx_flags_o = '0;
		tx_flags_o[`FLAG_SOF_BIT] = tx_src_rdy_o && (word_idx == '0);
		tx_flags_o[`FLAG_EOF_BIT] = tx_src_rdy_o && last_word;
	end

	// Pop the granted source on each transfer
	assign pri_rd_o = xfer && (state == SND_PRI);
	assign sec_rd_o = xfer && (state == SND_SEC);

	////////////////////////////////////////
	// Arbiter FSM

	always_comb begin
		state_nxt = state;
		case (state)
			SND_IDLE: begin
				// Config beats ADC when both are ready
				if (pri_pkt_ready_i)
					state_nxt = SND_PRI;
				else if (sec_pkt_ready_i)
					state_nxt = SND_SEC;
			end
			SND_PRI, SND_SEC: begin
				if (xfer && last_word)
					state_nxt = SND_IDLE;	// One idle cycle between packets
			end
			default: state_nxt = SND_IDLE;
		endcase
	end

	always_ff @(posedge GMII_GTX_CLK_int) begin
		if (rst_mux_div) begin
			state    <= SND_IDLE;
			word_idx <= '0;
		end else begin
			state <= state_nxt;
			if (state == SND_IDLE)
				word_idx <= '0;
			else if (xfer)
				word_idx <= word_idx + 1'b1;
		end
	end

	// Stalled word must not change until it is taken
	a_stall_stable: assert property (
		@(posedge GMII_GTX_CLK_int) disable iff (rst_mux_div)
		tx_src_rdy_o && !tx_dst_rdy_i |=>
			tx_src_rdy_o && $stable(tx_data_o) && $stable(tx_flags_o)
	) else $error("packet_sender: stream changed while stalled");

endmodule

// ==== sample_fifo.sv ====
`timescale 1ns/1ps
`include "daq_params.svh"

module sample_fifo
	import daq_pkg::*;
(
	input  logic       GMII_GTX_CLK_int,
	input  logic       rst_mux_div,
	input  logic       wr_en_i,
	input  data_word_t wr_data_i,
	input  logic       rd_en_i,
	output data_word_t rd_data_o,
	output logic       pkt_ready_o,
	output logic       full_o
);

	localparam int DEPTH = 1 << `FIFO_AW;

	data_word_t          mem [0:DEPTH-1];
	logic [`FIFO_AW-1:0] wr_ptr;
	logic [`FIFO_AW-1:0] rd_ptr;
	fifo_cnt_t           fill;
	fifo_cnt_t           fill_nxt;
	logic                wr_ok;
	logic                rd_ok;
	logic                empty;

	assign full_o = (fill == fifo_cnt_t'(DEPTH));
	assign empty  = (fill == '0);
	assign wr_ok  = wr_en_i & ~full_o;
	assign rd_ok  = rd_en_i & ~empty;

	// Head word is visible without a read
	assign rd_data_o = mem[rd_ptr];

	always_comb begin
		case ({wr_ok, rd_ok})
			2'b10:   fill_nxt = fill + fifo_cnt_t'(1);
			2'b01:   fill_nxt = fill - fifo_cnt_t'(1);
			default: fill_nxt = fill;	// Idle or both at once
		endcase
	end

	always_ff @(posedge GMII_GTX_CLK_int) begin
		if (wr_ok)
			mem[wr_ptr] <= wr_data_i;
	end

	always_ff @(posedge GMII_GTX_CLK_int) begin
		if (rst_mux_div) begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			fill        <= '0;
			pkt_ready_o <= 1'b0;
		end else begin
			if (wr_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_ok)
				rd_ptr <= rd_ptr + 1'b1;
			fill <= fill_nxt;
			// Threshold on the new level, so the flag never lags a pop
			pkt_ready_o <= (fill_nxt >= fifo_cnt_t'(`PKT_WORDS));
		end
	end

	// Source side has to watch full
	a_no_overflow: assert property (
		@(posedge GMII_GTX_CLK_int) disable iff (rst_mux_div)
		wr_en_i |-> !full_o
	) else $error("sample_fifo: write while full");

	// Sender only pops words that a packet-ready flag promised
	a_no_underflow: assert property (
		@(posedge GMII_GTX_CLK_int) disable iff (rst_mux_div)
		rd_en_i |-> !empty
	) else $error("sample_fifo: read while empty");

endmodule

// ==== daq_pkg.sv ====
`include "daq_params.svh"

package daq_pkg;

	// One sample or stream word
	typedef logic [`DATA_W-1:0] data_word_t;

	// Only SOF and EOF are used, the rest stay zero
	typedef logic [`FLAG_W-1:0] stream_flags_t;

	// Fill level, one bit wider than the address
	typedef logic [`FIFO_AW:0] fifo_cnt_t;

	// Word index inside a packet
	typedef logic [6:0] pkt_cnt_t;

	typedef logic [`MUX_W-1:0] mux_word_t;

	typedef enum logic [1:0] {
		SND_IDLE,
		SND_PRI,	// Config source granted
		SND_SEC 	// ADC source granted
	} sender_state_t;

	typedef enum logic {
		SYNC_HUNT,	// Training
		SYNC_LOCKED
	} sync_state_t;

endpackage

// ==== daq_params.svh ====
`ifndef DAQ_PARAMS_SVH
`define DAQ_PARAMS_SVH

// Sample and stream word
`define DATA_W 32
`define FLAG_W 4

// Sample FIFO, 512 words deep
`define FIFO_AW 9

// Same packet length for ADC and config
`define PKT_WORDS 128

// Serial mux parallel word
`define MUX_W 8

// Training patterns
`define SYNC_IDLE 8'h01
`define SYNC_LOCK 8'h81

// Positions in the stream flags
`define FLAG_SOF_BIT 0
`define FLAG_EOF_BIT 1

`endif
